// File: core_mem.f
+incdir+.
l1_pkg.sv
lsu_req_if.sv
l1_mem_if.sv
lsu_arbiter.sv
core_l1_cache.sv
data_memory.sv
core_mem_top.sv
core_mem_props.sv
tb_core_mem.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core_mem \
    -f core_mem.f -o sim_core_mem || exit 1

result=$(./obj_dir/sim_core_mem)
echo "$result"
echo "$result" | grep -qx "all tests passed" && echo "Simulation PASSED" || {
    echo "Simulation FAILED"
    exit 1
}

// File: tb_core_mem.sv
/* Directed tests for the core memory path, checked against a write-back
   reference model. Only the fairness test has several LSUs in flight */
`timescale 1ns/1ps
`include "l1_macros.svh"

module tb_core_mem
    import l1_pkg::*;
();

    localparam int PERIOD_NS = 8;
    localparam int RESET_CYCLES = 10;
    // Worst request is a dirty writeback plus a fill, with arbiter and cache overhead
    localparam int WORST_CYCLES = 2 * (`L1_MEM_LATENCY + 1) + 8;
    localparam int REQ_BUDGET = 150;
    localparam int WATCHDOG_NS = (RESET_CYCLES + REQ_BUDGET * WORST_CYCLES) * PERIOD_NS;

    logic clk = 1'b0;
    logic reset;
    logic [`L1_NUM_LSU-1:0] lsu_read_valid;
    logic [`L1_ADDR_BITS-1:0] lsu_read_address [`L1_NUM_LSU];
    logic [`L1_NUM_LSU-1:0] lsu_read_ready;
    logic [`L1_DATA_BITS-1:0] lsu_read_data [`L1_NUM_LSU];
    logic [`L1_NUM_LSU-1:0] lsu_write_valid;
    logic [`L1_ADDR_BITS-1:0] lsu_write_address [`L1_NUM_LSU];
    logic [`L1_DATA_BITS-1:0] lsu_write_data [`L1_NUM_LSU];
    logic [`L1_NUM_LSU-1:0] lsu_write_ready;
    logic cache_invalidate;
    logic [15:0] hit_count;
    logic [15:0] miss_count;

    // Reference model: backing memory plus per-line tag, data and flags
    logic [`L1_DATA_BITS-1:0] backing [1 << `L1_ADDR_BITS];
    logic [`L1_TAG_BITS-1:0] model_tag [`L1_LINES];
    logic [`L1_DATA_BITS-1:0] model_data [`L1_LINES];
    logic [`L1_LINES-1:0] model_valid;
    logic [`L1_LINES-1:0] model_dirty;
    int exp_hits;
    int exp_misses;
    int req_total;
    int errors;
    int served [$];
    logic [31:0] lcg_state;

    core_mem_top i_dut (.*);

    always #(PERIOD_NS / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, a request was never answered", $time);
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED at %0t: %s expected %0h got %0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Applies one served request to the model and returns what a read must see
    function automatic logic [7:0] model_access(input lsu_op_t op, input logic [7:0] addr,
                                                input logic [7:0] wdata);
        l1_addr_u a;
        l1_addr_u victim;
        logic [7:0] result;
        a.raw = addr;
        result = 8'h00;
        req_total++;
        if (model_valid[a.f.index] && (model_tag[a.f.index] == a.f.tag)) begin
            exp_hits++;
            if (op == op_read) begin
                result = model_data[a.f.index];
            end else begin
                model_data[a.f.index] = wdata;
                model_dirty[a.f.index] = 1'b1;
            end
        end else begin
            exp_misses++;
            if (model_valid[a.f.index] && model_dirty[a.f.index]) begin
                victim.f.tag = model_tag[a.f.index];
                victim.f.index = a.f.index;
                backing[victim.raw] = model_data[a.f.index];
            end
            // Write miss goes through to memory and the line is allocated clean
            if (op == op_write) begin
                backing[addr] = wdata;
            end
            result = backing[addr];
            model_data[a.f.index] = result;
            model_tag[a.f.index] = a.f.tag;
            model_valid[a.f.index] = 1'b1;
            model_dirty[a.f.index] = 1'b0;
        end
        return result;
    endfunction

    task automatic do_read(input int id, input logic [7:0] addr, output logic [7:0] data);
        logic [7:0] expected;
        @(posedge clk);
        lsu_read_address[id] <= addr;
        lsu_read_valid[id] <= 1'b1;
        // Ready is a registered pulse, sampled away from the rising edge
        do begin
            @(negedge clk);
        end while (!lsu_read_ready[id]);
        data = lsu_read_data[id];
        served.push_back(id);
        expected = model_access(op_read, addr, 8'h00);
        check_value("lsu_read_data", 16'(expected), 16'(data));
        @(posedge clk);
        lsu_read_valid[id] <= 1'b0;
    endtask

    task automatic do_write(input int id, input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        lsu_write_address[id] <= addr;
        lsu_write_data[id] <= data;
        lsu_write_valid[id] <= 1'b1;
        do begin
            @(negedge clk);
        end while (!lsu_write_ready[id]);
        served.push_back(id);
        void'(model_access(op_write, addr, data));
        @(posedge clk);
        lsu_write_valid[id] <= 1'b0;
    endtask

    task automatic pulse_invalidate();
        @(posedge clk);
        cache_invalidate <= 1'b1;
        @(posedge clk);
        cache_invalidate <= 1'b0;
        model_valid = '0;
        model_dirty = '0;
    endtask

    task automatic check_counters();
        @(negedge clk);
        check_value("hit_count", 16'(exp_hits), hit_count);
        check_value("miss_count", 16'(exp_misses), miss_count);
    endtask

    task automatic hit_miss_sequence();
        logic [7:0] data;
        logic [15:0] hits_before;
        do_read(0, 8'h21, data);
        check_value("lsu_read_data", 16'h0000, 16'(data));
        do_read(2, 8'h32, data);
        check_value("lsu_read_data", 16'h0000, 16'(data));
        do_write(1, 8'h45, 8'h5a);
        do_read(1, 8'h45, data);
        check_value("lsu_read_data", 16'h005a, 16'(data));
        hits_before = 16'(exp_hits);
        do_read(3, 8'h45, data);
        check_value("lsu_read_data", 16'h005a, 16'(data));
        @(negedge clk);
        check_value("hit_count", hits_before + 16'd1, hit_count);
        check_counters();
    endtask

    task automatic evict_dirty_line();
        l1_addr_u addr_a;
        l1_addr_u addr_b;
        logic [7:0] data;
        addr_a.raw = 8'h13;
        // Same index, different tag
        addr_b = addr_a;
        addr_b.f.tag = addr_a.f.tag + 4'd1;
        do_write(0, addr_a.raw, 8'h11);
        do_write(2, addr_a.raw, 8'h22);
        do_read(1, addr_b.raw, data);
        do_read(3, addr_a.raw, data);
        check_value("lsu_read_data", 16'h0022, 16'(data));
        check_counters();
    endtask

    task automatic invalidate_dirty_line();
        logic [7:0] data;
        do_write(2, 8'h5c, 8'h77);
        do_write(2, 8'h5c, 8'h99);
        pulse_invalidate();
        do_read(0, 8'h5c, data);
        check_value("lsu_read_data", 16'h0077, 16'(data));
        check_counters();
    endtask

    task automatic round_robin_order();
        logic [7:0] data;
        // LSU 3 served last, so the pointer starts at LSU 0
        do_read(3, 8'h60, data);
        served.delete();
        fork
            begin
                logic [7:0] d0;
                do_read(0, 8'h01, d0);
                do_write(0, 8'h05, 8'ha5);
            end
            do_write(1, 8'h02, 8'h3c);
            begin
                logic [7:0] d2;
                do_read(2, 8'h03, d2);
            end
            do_write(3, 8'h04, 8'h4b);
        join
        if (served.size() != 5) begin
            $display("Round-robin test saw %0d ready pulses instead of 5", served.size());
            errors++;
        end else begin
            for (int k = 0; k < 5; k++) begin
                check_value("served_lsu", 16'(k % 4), 16'(served[k]));
            end
        end
        check_counters();
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [7:0] addr;
        logic [7:0] data;
        int id;
        for (int n = 0; n < 60; n++) begin
            r = lcg_next();
            id = int'(r[17:16]);
            // Tags 0 to 3 only, so lines get reused and evicted
            addr = {2'b00, r[29:24]};
            if (r[31]) begin
                do_write(id, addr, r[15:8]);
            end else begin
                do_read(id, addr, data);
            end
        end
        check_counters();
    endtask

    initial begin
        reset = 1'b1;
        cache_invalidate = 1'b0;
        lsu_read_valid = '0;
        lsu_write_valid = '0;
        for (int i = 0; i < `L1_NUM_LSU; i++) begin
            lsu_read_address[i] = '0;
            lsu_write_address[i] = '0;
            lsu_write_data[i] = '0;
        end
        for (int i = 0; i < (1 << `L1_ADDR_BITS); i++) begin
            backing[i] = '0;
        end
        model_valid = '0;
        model_dirty = '0;
        exp_hits = 0;
        exp_misses = 0;
        req_total = 0;
        errors = 0;
        lcg_state = 32'd13;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        hit_miss_sequence();
        evict_dirty_line();
        invalidate_dirty_line();
        round_robin_order();
        random_traffic();
        @(negedge clk);
        check_value("hit_count + miss_count", 16'(req_total), hit_count + miss_count);
        $display("Summary: %0d requests, %0d check errors, %0d assertion failures",
                 req_total, errors, i_dut.i_cache.i_props.fail_count);
        if (errors == 0 && i_dut.i_cache.i_props.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: core_mem_props.sv
/* Handshake checks on the L1 cache, bound into every core_l1_cache.
   Done must follow a request within a bound set by the memory latency */
`timescale 1ns/1ps
`include "l1_macros.svh"

module core_mem_props (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input logic done,
    input logic rd_valid,
    input logic wr_valid,
    input logic mem_ready,
    input logic [`L1_ADDR_BITS-1:0] mem_addr,
    input logic [`L1_DATA_BITS-1:0] mem_wdata
);

    localparam int DONE_LIMIT = 4 * `L1_MEM_LATENCY + 8;

    int wait_cycles;
    int fail_count = 0;

    // Cycles the current request has waited for done
    always_ff @(posedge clk) begin
        if (reset || !req_valid || done) begin
            wait_cycles <= 0;
        end else begin
            wait_cycles <= wait_cycles + 1;
        end
    end

    // The arbiter drops valid right after the done pulse
    done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> (!done && !req_valid))
        else begin
            fail_count++;
            $error("done not a single pulse or req valid held after done");
        end

    one_mem_op: assert property (@(posedge clk) disable iff (reset)
        !(rd_valid && wr_valid) && (!mem_ready || rd_valid || wr_valid))
        else begin
            fail_count++;
            $error("memory valids overlap or ready without a request");
        end

    rd_hold: assert property (@(posedge clk) disable iff (reset)
        (rd_valid && !mem_ready) |=> (rd_valid && $stable(mem_addr)))
        else begin
            fail_count++;
            $error("rd_valid or address changed before ready");
        end

    wr_hold: assert property (@(posedge clk) disable iff (reset)
        (wr_valid && !mem_ready) |=> (wr_valid && $stable(mem_addr) && $stable(mem_wdata)))
        else begin
            fail_count++;
            $error("wr_valid or write fields changed before ready");
        end

    done_bound: assert property (@(posedge clk) disable iff (reset) wait_cycles <= DONE_LIMIT)
        else begin
            fail_count++;
            $error("request not answered by done in time");
        end

endmodule

bind core_l1_cache core_mem_props i_props (
    .clk(clk),
    .reset(reset),
    .req_valid(req.valid),
    .done(req.done),
    .rd_valid(mem.rd_valid),
    .wr_valid(mem.wr_valid),
    .mem_ready(mem.ready),
    .mem_addr(mem.addr),
    .mem_wdata(mem.wdata)
);

// File: core_mem_top.sv
/* Memory path of one core: LSU arbiter, L1 data cache, data memory.
   Each LSU holds read or write valid, never both, until its ready */
`timescale 1ns/1ps
`include "l1_macros.svh"

module core_mem_top (
    input logic clk,
    input logic reset,

    // LSU reads
    input logic [`L1_NUM_LSU-1:0] lsu_read_valid,
    input logic [`L1_ADDR_BITS-1:0] lsu_read_address [`L1_NUM_LSU],
    output logic [`L1_NUM_LSU-1:0] lsu_read_ready,
    output logic [`L1_DATA_BITS-1:0] lsu_read_data [`L1_NUM_LSU],

    // LSU writes
    input logic [`L1_NUM_LSU-1:0] lsu_write_valid,
    input logic [`L1_ADDR_BITS-1:0] lsu_write_address [`L1_NUM_LSU],
    input logic [`L1_DATA_BITS-1:0] lsu_write_data [`L1_NUM_LSU],
    output logic [`L1_NUM_LSU-1:0] lsu_write_ready,

    // Cache control and statistics
    input logic cache_invalidate,
    output logic [15:0] hit_count,
    output logic [15:0] miss_count
);

    lsu_req_if req_bus ();
    l1_mem_if mem_bus ();

    lsu_arbiter i_arbiter (
        .clk(clk),
        .reset(reset),
        .read_valid(lsu_read_valid),
        .read_address(lsu_read_address),
        .write_valid(lsu_write_valid),
        .write_address(lsu_write_address),
        .write_data(lsu_write_data),
        .read_ready(lsu_read_ready),
        .read_data(lsu_read_data),
        .write_ready(lsu_write_ready),
        .req(req_bus.arbiter)
    );

    core_l1_cache i_cache (
        .clk(clk),
        .reset(reset),
        .cache_invalidate(cache_invalidate),
        .req(req_bus.cache),
        .mem(mem_bus.cache),
        .hit_count(hit_count),
        .miss_count(miss_count)
    );

    data_memory i_memory (
        .clk(clk),
        .reset(reset),
        .mem(mem_bus.memory)
    );

endmodule

// File: data_memory.sv
/* 256-byte backing store, zero after reset. Answers one transfer at a
   time, with ready exactly L1_MEM_LATENCY cycles after valid rises */
`timescale 1ns/1ps
`include "l1_macros.svh"

module data_memory (
    input logic clk,
    input logic reset,
    l1_mem_if.memory mem
);

    localparam int WORDS = 1 << `L1_ADDR_BITS;
    localparam int CNT_W = $clog2(`L1_MEM_LATENCY + 1);

    logic [`L1_DATA_BITS-1:0] store [WORDS];
    logic [CNT_W-1:0] wait_cnt;
    logic active;
    logic last_cycle;

    // Idle during the ready cycle so a held valid does not restart the count
    assign active = (mem.rd_valid || mem.wr_valid) && !mem.ready;
    assign last_cycle = (wait_cnt == CNT_W'(`L1_MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            mem.ready <= 1'b0;
            wait_cnt <= '0;
            for (int i = 0; i < WORDS; i++) begin
                store[i] <= '0;
            end
        end else begin
            mem.ready <= 1'b0;
            if (active) begin
                if (last_cycle) begin
                    mem.ready <= 1'b1;
                    wait_cnt <= '0;
                    // Write lands together with the ready pulse
                    if (mem.wr_valid) begin
                        store[mem.addr] <= mem.wdata;
                    end
                end else begin
                    wait_cnt <= wait_cnt + CNT_W'(1);
                end
            end
        end
    end

    // Read data shows up in the ready cycle
    always_ff @(posedge clk) begin
        if (active && last_cycle && mem.rd_valid) begin
            mem.rdata <= store[mem.addr];
        end
    end

endmodule

// File: core_l1_cache.sv
/* Direct-mapped L1, one byte per line, one request at a time. Write
   misses go through to memory; cache_invalidate drops dirty data */
`timescale 1ns/1ps
`include "l1_macros.svh"

module core_l1_cache
    import l1_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic cache_invalidate,
    lsu_req_if.cache req,
    l1_mem_if.cache mem,
    output logic [15:0] hit_count,
    output logic [15:0] miss_count
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL_READ,
        WRITE_THROUGH,
        COMPLETE
    } cache_state_t;

    cache_state_t state;
    cache_state_t next_state;

    // Line storage
    logic [`L1_TAG_BITS-1:0] tag_mem [`L1_LINES];
    logic [`L1_DATA_BITS-1:0] data_mem [`L1_LINES];
    logic [`L1_LINES-1:0] line_valid;
    logic [`L1_LINES-1:0] line_dirty;

    logic [`L1_INDEX_BITS-1:0] idx;
    logic line_hit;
    logic victim_dirty;
    logic alloc;
    logic [`L1_DATA_BITS-1:0] fill_data;

    // Dirty line waiting to go back to memory
    l1_addr_u victim_addr;
    logic [`L1_DATA_BITS-1:0] victim_data;

    // Request fields stay stable until done, so index straight from them
    assign idx = req.addr.f.index;
    assign line_hit = line_valid[idx] && (tag_mem[idx] == req.addr.f.tag);
    assign victim_dirty = line_valid[idx] && line_dirty[idx];
    assign alloc = ((state == FILL_READ) || (state == WRITE_THROUGH)) && mem.ready;
    assign fill_data = (state == FILL_READ) ? mem.rdata : req.wdata;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req.valid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (line_hit) begin
                    next_state = COMPLETE;
                end else if (victim_dirty) begin
                    next_state = WRITEBACK;
                end else if (req.op == op_read) begin
                    next_state = FILL_READ;
                end else begin
                    next_state = WRITE_THROUGH;
                end
            end
            WRITEBACK: begin
                if (mem.ready) begin
                    next_state = (req.op == op_read) ? FILL_READ : WRITE_THROUGH;
                end
            end
            FILL_READ, WRITE_THROUGH: begin
                if (mem.ready) begin
                    next_state = COMPLETE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // State, line flags and counters
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            line_valid <= '0;
            line_dirty <= '0;
            hit_count <= '0;
            miss_count <= '0;
        end else begin
            state <= next_state;
            if (cache_invalidate) begin
                line_valid <= '0;
                line_dirty <= '0;
            end
            if (state == LOOKUP) begin
                if (line_hit) begin
                    hit_count <= hit_count + 16'd1;
                    if (req.op == op_write) begin
                        line_dirty[idx] <= 1'b1;
                    end
                end else begin
                    miss_count <= miss_count + 16'd1;
                end
            end
            // Allocation comes last so it wins over a same-cycle invalidate
            if (alloc) begin
                line_valid[idx] <= 1'b1;
                line_dirty[idx] <= 1'b0;
            end
        end
    end

    // Tags, data, victim capture and read data
    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            if (line_hit) begin
                if (req.op == op_read) begin
                    req.rdata <= data_mem[idx];
                end else begin
                    data_mem[idx] <= req.wdata;
                end
            end else if (victim_dirty) begin
                victim_addr.f.tag <= tag_mem[idx];
                victim_addr.f.index <= idx;
                victim_data <= data_mem[idx];
            end
        end
        if (alloc) begin
            tag_mem[idx] <= req.addr.f.tag;
            data_mem[idx] <= fill_data;
            if (state == FILL_READ) begin
                req.rdata <= mem.rdata;
            end
        end
    end

    // Memory requests follow the state directly
    assign mem.rd_valid = (state == FILL_READ);
    assign mem.wr_valid = (state == WRITEBACK) || (state == WRITE_THROUGH);
    assign mem.addr = (state == WRITEBACK) ? victim_addr.raw : req.addr.raw;
    assign mem.wdata = (state == WRITEBACK) ? victim_data : req.wdata;

    assign req.done = (state == COMPLETE);

endmodule

// File: lsu_arbiter.sv
/* Round-robin over the LSUs, one request in flight. No new grant while
   a ready pulse is out, so the served LSU can drop its valid first */
`timescale 1ns/1ps
`include "l1_macros.svh"

module lsu_arbiter
    import l1_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic [`L1_NUM_LSU-1:0] read_valid,
    input logic [`L1_ADDR_BITS-1:0] read_address [`L1_NUM_LSU],
    input logic [`L1_NUM_LSU-1:0] write_valid,
    input logic [`L1_ADDR_BITS-1:0] write_address [`L1_NUM_LSU],
    input logic [`L1_DATA_BITS-1:0] write_data [`L1_NUM_LSU],
    output logic [`L1_NUM_LSU-1:0] read_ready,
    output logic [`L1_DATA_BITS-1:0] read_data [`L1_NUM_LSU],
    output logic [`L1_NUM_LSU-1:0] write_ready,
    lsu_req_if.arbiter req
);

    localparam int ID_W = `L1_LSU_ID_BITS;

    logic [ID_W-1:0] last_id;
    logic [ID_W-1:0] grant_id;
    logic [ID_W-1:0] pick_id;
    logic [ID_W-1:0] cand;
    logic pick_found;
    logic resp_busy;
    logic grant_now;

    // First pending LSU after the last one served
    always_comb begin
        pick_found = 1'b0;
        pick_id = last_id;
        cand = last_id;
        for (int k = 1; k <= `L1_NUM_LSU; k++) begin
            cand = last_id + ID_W'(k);
            if (!pick_found && (read_valid[cand] || write_valid[cand])) begin
                pick_found = 1'b1;
                pick_id = cand;
            end
        end
    end

    assign resp_busy = (|read_ready) || (|write_ready);
    assign grant_now = !req.valid && pick_found && !resp_busy;

    // Grant lock and response pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
            grant_id <= '0;
            last_id <= ID_W'(`L1_NUM_LSU - 1);
            read_ready <= '0;
            write_ready <= '0;
        end else begin
            read_ready <= '0;
            write_ready <= '0;
            if (req.valid && req.done) begin
                req.valid <= 1'b0;
                // Advance past the served LSU so a waiting neighbor goes next
                last_id <= grant_id;
                if (req.op == op_read) begin
                    read_ready[grant_id] <= 1'b1;
                end else begin
                    write_ready[grant_id] <= 1'b1;
                end
            end else if (grant_now) begin
                req.valid <= 1'b1;
                grant_id <= pick_id;
            end
        end
    end

    // Request fields and returned read data
    always_ff @(posedge clk) begin
        if (grant_now) begin
            req.op <= read_valid[pick_id] ? op_read : op_write;
            req.addr.raw <= read_valid[pick_id] ? read_address[pick_id]
                                                : write_address[pick_id];
            req.wdata <= write_data[pick_id];
        end
        if (req.valid && req.done && (req.op == op_read)) begin
            read_data[grant_id] <= req.rdata;
        end
    end

endmodule

// File: l1_mem_if.sv
/* Cache to data memory transfers. At most one of rd_valid and wr_valid
   is high, held with the fields until the ready pulse */
`timescale 1ns/1ps
`include "l1_macros.svh"

interface l1_mem_if ();

    // Driven by the cache
    logic rd_valid;
    logic wr_valid;
    logic [`L1_ADDR_BITS-1:0] addr;
    logic [`L1_DATA_BITS-1:0] wdata;

    // Driven by the memory, rdata valid with ready
    logic ready;
    logic [`L1_DATA_BITS-1:0] rdata;

    modport cache (
        output rd_valid, wr_valid, addr, wdata,
        input ready, rdata
    );

    modport memory (
        input rd_valid, wr_valid, addr, wdata,
        output ready, rdata
    );

endinterface

// File: lsu_req_if.sv
/* One granted LSU request between arbiter and cache. Valid and the
   fields stay stable until the one-cycle done pulse */
`timescale 1ns/1ps
`include "l1_macros.svh"

interface lsu_req_if
    import l1_pkg::*;
();

    // Request side, owned by the arbiter
    logic valid;
    lsu_op_t op;
    l1_addr_u addr;
    logic [`L1_DATA_BITS-1:0] wdata;

    // Completion side, owned by the cache
    logic done;
    logic [`L1_DATA_BITS-1:0] rdata;

    modport arbiter (
        output valid, op, addr, wdata,
        input done, rdata
    );

    modport cache (
        input valid, op, addr, wdata,
        output done, rdata
    );

endinterface

// File: l1_pkg.sv
/* Types shared by the arbiter, the cache and the testbench.
   The tag sits in the high bits of the address word */
`include "l1_macros.svh"

package l1_pkg;

    // Tag and index view of an address
    typedef struct packed {
        logic [`L1_TAG_BITS-1:0] tag;
        logic [`L1_INDEX_BITS-1:0] index;
    } l1_addr_fields_t;

    // One address word, seen raw or split into tag and index
    typedef union packed {
        logic [`L1_ADDR_BITS-1:0] raw;
        l1_addr_fields_t f;
    } l1_addr_u;

    // LSU operation carried with a granted request
    typedef enum logic {
        op_read = 1'b0,
        op_write = 1'b1
    } lsu_op_t;

endpackage

// File: l1_macros.svh
/* Sizes for the core memory path. Tag plus index bits must equal the
   address width, and L1_LSU_ID_BITS must cover L1_NUM_LSU */
`ifndef L1_MACROS_SVH
`define L1_MACROS_SVH

// Address and data words
`define L1_ADDR_BITS 8
`define L1_DATA_BITS 8

// Requesters per core
`define L1_NUM_LSU 4
`define L1_LSU_ID_BITS 2

// Direct-mapped geometry, one byte per line
`define L1_LINES 16
`define L1_TAG_BITS 4
`define L1_INDEX_BITS 4

// Cycles from memory valid to memory ready
`define L1_MEM_LATENCY 3

`endif
